//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpuTb
FILELIST = pipelineCpu.f
OBJDIR = obj_dir
PASS_TEXT = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

//--- pipelineCpu.f
source/cpuPkg.sv
source/pipeBuses.sv
source/fetchUnit.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memoryUnit.sv
source/pipelineCpu.sv
testbench/cpuChecker.sv
testbench/cpuTb_assert.sv
testbench/cpuTb.sv

//--- source/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [7:0] imemAddr_t;
	typedef logic [7:0] dmemAddr_t;

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	// Opcodes
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_LI = 6'b001001;
	localparam opcode_t OP_LW = 6'b100011;
	localparam opcode_t OP_SW = 6'b101011;
	localparam opcode_t OP_BNE = 6'b000101;
	localparam opcode_t OP_XORI = 6'b001110;

	// R-type function codes
	localparam func_t FUNC_ADD = 6'b100000;
	localparam func_t FUNC_SUB = 6'b100010;
	localparam func_t FUNC_SLT = 6'b101010;

	// Instruction field positions with func at bit 0
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int IMM_WIDTH = 16;

endpackage

//--- source/decodeUnit.sv
`timescale 1ns/1ns

module decodeUnit (
	input  logic clk,
	input  logic rst,
	input  cpuPkg::word_t instr,
	input  logic instrValid,
	input  logic branchTaken,
	input  logic wbValid,
	input  cpuPkg::regAddr_t wbReg,
	input  cpuPkg::word_t wbData,
	output logic stall,
	decodeExBus.dec idEx
);
	import cpuPkg::*;

	word_t regFile [32];

	opcode_t opcode;
	func_t func;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	word_t immediate;
	word_t rsData;
	word_t rtData;
	imemAddr_t fetchPc;
	logic usesRs;
	logic usesRt;
	logic loadHazard;

	// Field split
	assign opcode = instr[OPCODE_LSB +: $bits(opcode_t)];
	assign func = instr[$bits(func_t)-1:0];
	assign rs = instr[RS_LSB +: $bits(regAddr_t)];
	assign rt = instr[RT_LSB +: $bits(regAddr_t)];
	assign rd = instr[RD_LSB +: $bits(regAddr_t)];
	assign immediate = {{($bits(word_t) - IMM_WIDTH){instr[IMM_WIDTH-1]}}, instr[IMM_WIDTH-1:0]};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbValid && wbReg != '0) begin
			regFile[wbReg] <= wbData;
		end
	end

	// Register 0 reads zero and a retiring write shows through
	assign rsData = (rs == '0) ? '0 : (wbValid && wbReg == rs) ? wbData : regFile[rs];
	assign rtData = (rt == '0) ? '0 : (wbValid && wbReg == rt) ? wbData : regFile[rt];

	// Mirror of the fetch PC with the decode instruction one below it
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchPc <= '0;
		end else if (branchTaken) begin
			fetchPc <= idEx.branchTarget;
		end else if (!stall) begin
			fetchPc <= fetchPc + imemAddr_t'(1);
		end
	end

	// Load-use check against the load waiting in execute
	assign usesRs = (opcode != OP_LI);
	assign usesRt = (opcode == OP_RTYPE) || (opcode == OP_SW) || (opcode == OP_BNE);
	assign loadHazard = idEx.valid && (idEx.opcode == OP_LW) && (idEx.rt != '0) &&
		((usesRs && rs == idEx.rt) || (usesRt && rt == idEx.rt));
	assign stall = instrValid && loadHazard;

	// Bubble on a stall or a taken branch
	always_ff @(posedge clk) begin
		if (rst) begin
			idEx.valid <= 1'b0;
		end else begin
			idEx.valid <= instrValid && !stall && !branchTaken;
		end
	end

	always_ff @(posedge clk) begin
		idEx.opcode <= opcode;
		idEx.func <= func;
		idEx.rs <= rs;
		idEx.rt <= rt;
		idEx.rd <= rd;
		idEx.operandA <= rsData;
		idEx.operandB <= rtData;
		idEx.immediate <= immediate;
		idEx.branchTarget <= fetchPc + imemAddr_t'(immediate);
	end

endmodule

//--- source/executeUnit.sv
`timescale 1ns/1ns

module executeUnit (
	input  logic clk,
	input  logic rst,
	decodeExBus.exe idEx,
	exMemBus.exe exMem,
	input  logic wbValid,
	input  cpuPkg::regAddr_t wbReg,
	input  cpuPkg::word_t wbData,
	output logic branchTaken,
	output cpuPkg::imemAddr_t branchTarget
);
	import cpuPkg::*;

	logic exFwdOk;
	word_t fwdA;
	word_t fwdB;
	word_t aluResult;
	logic writesReg;
	regAddr_t destReg;

	// Loads never forward from here since the decode stall covers them
	assign exFwdOk = exMem.valid && exMem.writesReg && !exMem.isLoad && (exMem.destReg != '0);

	assign fwdA = (exFwdOk && exMem.destReg == idEx.rs) ? exMem.result :
		(wbValid && wbReg == idEx.rs) ? wbData : idEx.operandA;
	assign fwdB = (exFwdOk && exMem.destReg == idEx.rt) ? exMem.result :
		(wbValid && wbReg == idEx.rt) ? wbData : idEx.operandB;

	always_comb begin
		aluResult = '0;
		writesReg = 1'b0;
		destReg = idEx.rt;
		case (idEx.opcode)
			OP_RTYPE: begin
				destReg = idEx.rd;
				writesReg = 1'b1;
				case (idEx.func)
					FUNC_ADD: aluResult = fwdA + fwdB;
					FUNC_SUB: aluResult = fwdA - fwdB;
					FUNC_SLT: aluResult = ($signed(fwdA) < $signed(fwdB)) ? word_t'(1) : '0;
					// Unknown func including the all-zero no-op
					default: writesReg = 1'b0;
				endcase
			end
			OP_XORI: begin
				aluResult = fwdA ^ idEx.immediate;
				writesReg = 1'b1;
			end
			OP_LI: begin
				aluResult = idEx.immediate;
				writesReg = 1'b1;
			end
			OP_LW: begin
				aluResult = fwdA + idEx.immediate;
				writesReg = 1'b1;
			end
			OP_SW: aluResult = fwdA + idEx.immediate;
			default: aluResult = '0;
		endcase
	end

	// BNE resolves here on forwarded operands
	assign branchTaken = idEx.valid && (idEx.opcode == OP_BNE) && (fwdA != fwdB);
	assign branchTarget = idEx.branchTarget;

	always_ff @(posedge clk) begin
		if (rst) begin
			exMem.valid <= 1'b0;
		end else begin
			exMem.valid <= idEx.valid;
		end
	end

	always_ff @(posedge clk) begin
		exMem.isLoad <= (idEx.opcode == OP_LW);
		exMem.isStore <= (idEx.opcode == OP_SW);
		exMem.writesReg <= writesReg;
		exMem.destReg <= destReg;
		exMem.result <= aluResult;
		exMem.storeData <= fwdB;
	end

endmodule

//--- source/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit (
	input  logic clk,
	input  logic rst,
	input  logic loadValid,
	input  cpuPkg::imemAddr_t loadAddr,
	input  cpuPkg::word_t loadData,
	input  logic stall,
	input  logic branchTaken,
	input  cpuPkg::imemAddr_t branchTarget,
	output cpuPkg::word_t instr,
	output logic instrValid
);
	import cpuPkg::*;

	word_t instrMem [IMEM_DEPTH];
	imemAddr_t pc;

	// Program image comes in through the load strobe
	always_ff @(posedge clk) begin
		if (loadValid) begin
			instrMem[loadAddr] <= loadData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			instrValid <= 1'b0;
		end else if (branchTaken) begin
			pc <= branchTarget;
			instrValid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + imemAddr_t'(1);
			instrValid <= 1'b1;
		end
	end

	// Fetch/decode instruction word held on a stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			instr <= instrMem[pc];
		end
	end

endmodule

//--- source/memoryUnit.sv
`timescale 1ns/1ns

module memoryUnit (
	input  logic clk,
	input  logic rst,
	exMemBus.mem exMem,
	output logic wbValid,
	output cpuPkg::regAddr_t wbReg,
	output cpuPkg::word_t wbData
);
	import cpuPkg::*;

	word_t dataMem [DMEM_DEPTH];
	dmemAddr_t addr;

	// Word address with the upper result bits ignored
	assign addr = dmemAddr_t'(exMem.result);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				dataMem[i] <= '0;
			end
		end else if (exMem.valid && exMem.isStore) begin
			dataMem[addr] <= exMem.storeData;
		end
	end

	// No writeback strobe for register 0
	always_ff @(posedge clk) begin
		if (rst) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= exMem.valid && exMem.writesReg && (exMem.destReg != '0);
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= exMem.destReg;
		wbData <= exMem.isLoad ? dataMem[addr] : exMem.result;
	end

endmodule

//--- source/pipeBuses.sv
`timescale 1ns/1ns

interface decodeExBus;
	import cpuPkg::*;

	logic valid;
	opcode_t opcode;
	func_t func;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	word_t operandA;
	word_t operandB;
	word_t immediate;
	imemAddr_t branchTarget;

	modport dec (
		output valid, opcode, func, rs, rt, rd,
		output operandA, operandB, immediate, branchTarget
	);

	modport exe (
		input valid, opcode, func, rs, rt, rd,
		input operandA, operandB, immediate, branchTarget
	);

endinterface

interface exMemBus;
	import cpuPkg::*;

	logic valid;
	logic isLoad;
	logic isStore;
	logic writesReg;
	regAddr_t destReg;
	word_t result;
	word_t storeData;

	modport exe (output valid, isLoad, isStore, writesReg, destReg, result, storeData);

	modport mem (input valid, isLoad, isStore, writesReg, destReg, result, storeData);

endinterface

//--- source/pipelineCpu.sv
`timescale 1ns/1ns

module pipelineCpu (
	input  logic clk,
	input  logic rst,
	input  logic loadValid,
	input  cpuPkg::imemAddr_t loadAddr,
	input  cpuPkg::word_t loadData,
	output logic wbValid,
	output cpuPkg::regAddr_t wbReg,
	output cpuPkg::word_t wbData
);
	import cpuPkg::*;

	word_t instr;
	logic instrValid;
	logic stall;
	logic branchTaken;
	imemAddr_t branchTarget;

	decodeExBus idEx ();
	exMemBus exMem ();

	fetchUnit u_fetch (
		.clk(clk),
		.rst(rst),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.stall(stall),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.instr(instr),
		.instrValid(instrValid)
	);

	decodeUnit u_decode (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.branchTaken(branchTaken),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.stall(stall),
		.idEx(idEx.dec)
	);

	executeUnit u_execute (
		.clk(clk),
		.rst(rst),
		.idEx(idEx.exe),
		.exMem(exMem.exe),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	// Writeback trace doubles as the register write path
	memoryUnit u_memory (
		.clk(clk),
		.rst(rst),
		.exMem(exMem.mem),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

//--- testbench/cpuChecker.sv
`timescale 1ns/1ns

module cpuChecker (
	input logic clk,
	input logic rst,
	input logic wbValid,
	input cpuPkg::regAddr_t wbReg,
	input cpuPkg::word_t wbData
);
	import cpuPkg::*;

	regAddr_t expRegs[$];
	word_t expVals[$];
	regAddr_t expReg;
	word_t expVal;
	string testName = "";
	int firstEdge = 0;
	int edgeCount = 0;
	int seenCount = 0;
	int pending = 0;
	int testErrors = 0;
	int testCount = 0;
	int failedTests = 0;
	int errorCount = 0;

	task automatic beginTest(input string name, input int first);
		testName = name;
		firstEdge = first;
		seenCount = 0;
		testErrors = 0;
		expRegs.delete();
		expVals.delete();
		pending = 0;
	endtask

	task automatic expectWrite(input regAddr_t r, input word_t v);
		expRegs.push_back(r);
		expVals.push_back(v);
		pending = expRegs.size();
	endtask

	task automatic reportTimeout();
		$display("Timeout in test %s: %0d writebacks never arrived", testName, pending);
		testErrors++;
	endtask

	task automatic endTest();
		testCount++;
		errorCount += testErrors;
		if (testErrors == 0) begin
			$display("Test %s passed with %0d writebacks", testName, seenCount);
		end else begin
			failedTests++;
			$display("Test %s failed with %0d errors", testName, testErrors);
		end
	endtask

	task automatic printSummary();
		$display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failedTests, errorCount);
	endtask

	// Edges since reset release with the first edge at rst low counted as 1
	always @(posedge clk) begin
		if (rst) begin
			edgeCount <= 0;
		end else begin
			edgeCount <= edgeCount + 1;
		end
	end

	// Trace sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && wbValid) begin
			if (pending == 0) begin
				$display("Extra writeback in test %s: r%0d = %h", testName, wbReg, wbData);
				testErrors++;
			end else begin
				expReg = expRegs.pop_front();
				expVal = expVals.pop_front();
				pending = expRegs.size();
				if (seenCount == 0 && firstEdge != 0 && edgeCount != firstEdge) begin
					$display("Fail %s first writeback: expected edge %0d, actual edge %0d",
						testName, firstEdge, edgeCount);
					testErrors++;
				end
				if (wbReg !== expReg || wbData !== expVal) begin
					$display("Fail %s: expected r%0d = %h, actual r%0d = %h",
						testName, expReg, expVal, wbReg, wbData);
					testErrors++;
				end
				seenCount++;
			end
		end
	end

endmodule

//--- testbench/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
	import cpuPkg::*;

	localparam int WAIT_LIMIT = 100;
	localparam int DRAIN_CYCLES = 8;

	logic clk;
	logic rst;
	logic loadValid;
	imemAddr_t loadAddr;
	word_t loadData;
	logic wbValid;
	regAddr_t wbReg;
	word_t wbData;

	word_t programWords[$];
	regAddr_t expRegs[$];
	word_t expVals[$];
	string testName;
	int firstEdge;
	int fd;
	logic runFailed;

	pipelineCpu u_dut (
		.clk(clk),
		.rst(rst),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	cpuChecker u_check (
		.clk(clk),
		.rst(rst),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Load the whole memory under reset then release it and wait for the trace
	task automatic runOneTest();
		int waited;
		@(posedge clk);
		rst <= 1'b1;
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			loadValid <= 1'b1;
			loadAddr <= imemAddr_t'(a);
			loadData <= (a < programWords.size()) ? programWords[a] : '0;
			@(posedge clk);
		end
		loadValid <= 1'b0;
		u_check.beginTest(testName, firstEdge);
		for (int k = 0; k < expRegs.size(); k++) begin
			u_check.expectWrite(expRegs[k], expVals[k]);
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		waited = 0;
		while (u_check.pending != 0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (u_check.pending != 0) begin
			u_check.reportTimeout();
		end else begin
			// Catch late extra writebacks
			for (int d = 0; d < DRAIN_CYCLES; d++) begin
				@(posedge clk);
			end
		end
		u_check.endTest();
	endtask

	task automatic flagBadLine(input string line);
		$display("Malformed line in the tests file: %s", line);
		runFailed = 1'b1;
	endtask

	task automatic readTests();
		string line;
		string tag;
		int fields;
		int wanted;
		int regNum;
		word_t value;
		while ($fgets(line, fd) != 0) begin
			tag = "";
			wanted = 0;
			fields = $sscanf(line, "%s", tag);
			if (tag == "test") begin
				fields = $sscanf(line, "%s %s", tag, testName);
				wanted = 2;
				programWords.delete();
				expRegs.delete();
				expVals.delete();
				firstEdge = 0;
			end else if (tag == "i") begin
				fields = $sscanf(line, "%s %h", tag, value);
				wanted = 2;
				programWords.push_back(value);
			end else if (tag == "e") begin
				fields = $sscanf(line, "%s %d %h", tag, regNum, value);
				wanted = 3;
				expRegs.push_back(regAddr_t'(regNum));
				expVals.push_back(value);
			end else if (tag == "first") begin
				fields = $sscanf(line, "%s %d", tag, firstEdge);
				wanted = 2;
			end else if (tag == "end") begin
				runOneTest();
			end
			if (wanted != 0 && fields != wanted) begin
				flagBadLine(line);
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		loadValid = 1'b0;
		loadAddr = '0;
		loadData = '0;
		runFailed = 1'b0;
		fd = $fopen("testbench/cpuTests.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/cpuTests.txt");
			runFailed = 1'b1;
		end else begin
			readTests();
			$fclose(fd);
			if (u_check.testCount == 0) begin
				$display("No tests found in the tests file");
				runFailed = 1'b1;
			end
		end
		u_check.printSummary();
		if (runFailed || u_check.errorCount != 0) begin
			$display("Done: errors found");
		end else begin
			$display("Done: no errors");
		end
		$finish;
	end

endmodule

//--- testbench/cpuTb_assert.sv
`timescale 1ns/1ns

module cpuAssert (
	input logic clk,
	input logic rst,
	input logic loadValid,
	input logic wbValid,
	input cpuPkg::regAddr_t wbReg
);

	// Once reset has held for a full cycle nothing retires
	quietInReset: assert property (@(posedge clk) (rst && $past(rst)) |-> !wbValid)
		else $error("wbValid high while rst is high");

	noRegZeroWrite: assert property (@(posedge clk) wbValid |-> (wbReg != '0))
		else $error("writeback to register 0 on the trace");

	loadOnlyInReset: assert property (@(posedge clk) loadValid |-> rst)
		else $error("loadValid high outside reset");

endmodule

bind pipelineCpu cpuAssert u_assert (
	.clk(clk),
	.rst(rst),
	.loadValid(loadValid),
	.wbValid(wbValid),
	.wbReg(wbReg)
);

//--- testbench/cpuTests.txt
# test <name> opens a block, i <hex word> is one instruction, e <reg> <hex value> is one writeback
# first <edge> is the edge count of the first writeback after reset release, end runs the block
test aluOps
i 2401000a
i 24020003
i 00000000
i 00000000
i 00221820
i 00222022
i 0041302a
i 0022382a
i 382500ff
e 1 0000000a
e 2 00000003
e 3 0000000d
e 4 00000007
e 6 00000001
e 7 00000000
e 5 000000f5
end
test forwarding
i 24010005
i 00211020
i 00411820
i 00622022
i 3885000f
e 1 00000005
e 2 0000000a
e 3 0000000f
e 4 00000005
e 5 0000000a
end
test memLoadUse
i 24010007
i 24020020
i ac410000
i 8c430000
i 00612020
e 1 00000007
e 2 00000020
e 3 00000007
e 4 0000000e
end
test branching
i 24010001
i 24020002
i 14220002
i 24030033
i 24040044
i 24050055
i 14210005
i 24060066
i 24070077
e 1 00000001
e 2 00000002
e 5 00000055
e 6 00000066
e 7 00000077
end
test resetTiming
first 4
i 24010009
i 24000005
i 00011020
e 1 00000009
e 2 00000009
end
